// File: build.f
logic/boot_pkg.sv
logic/cfg_loader.sv
logic/nbf_loader.sv
logic/cmd_router.sv
logic/mem_model.sv
logic/host_mmio.sv
logic/boot_top.sv
tests/boot_props.sv
tests/boot_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the boot subsystem simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module boot_tb -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vboot_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
   exit 0
fi
exit 1

// File: tests/boot_tb.sv
// Boot subsystem testbench
`timescale 1ns/1ps

module boot_tb
   import boot_pkg::*;
   ();

   localparam int TIMEOUT = 200;

   logic              clk;
   logic              arst_n;
   nbf_entry_s        nbf;
   logic              nbf_v;
   logic              nbf_ready;
   logic [DATA_W-1:0] rdata;
   logic              rdata_v;
   logic              loaded;
   logic              freeze;
   logic              finish;

   int                errors;
   int                checks;
   logic [ADDR_W-1:0] wr_addr [8];
   logic [DATA_W-1:0] wr_data [8];

   boot_top boot_top_i
     (.clk_i(clk)
      ,.arst_n_i(arst_n)
      ,.nbf_i(nbf)
      ,.nbf_v_i(nbf_v)
      ,.nbf_ready_o(nbf_ready)
      ,.nbf_rdata_o(rdata)
      ,.nbf_rdata_v_o(rdata_v)
      ,.loaded_o(loaded)
      ,.freeze_o(freeze)
      ,.program_finish_o(finish)
      );

   always #50 clk = ~clk;

   task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
      checks = checks + 1;
      if (act !== exp)
      begin
         errors = errors + 1;
         $display("ERROR: %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      checks = checks + 1;
      if (act !== exp)
      begin
         errors = errors + 1;
         $display("ERROR: %s expected %b actual %b", name, exp, act);
      end
   endtask

   // Valid goes up on a rising edge, ready is looked at on the falling edge
   task automatic send_entry(input nbf_op_e op, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data);
      int n;
      n = 0;
      @(posedge clk);
      nbf.op   <= op;
      nbf.addr <= addr;
      nbf.data <= data;
      nbf_v    <= 1'b1;
      @(negedge clk);
      while (!nbf_ready && n < TIMEOUT)
      begin
         n = n + 1;
         @(negedge clk);
      end
      if (!nbf_ready)
      begin
         errors = errors + 1;
         $display("Entry for address %h was never accepted by the loader", addr);
      end
      @(posedge clk);
      nbf_v <= 1'b0;
   endtask

   task automatic wait_ready(input string name);
      int n;
      n = 0;
      @(negedge clk);
      while (!nbf_ready && n < TIMEOUT)
      begin
         n = n + 1;
         @(negedge clk);
      end
      if (!nbf_ready)
      begin
         errors = errors + 1;
         $display("%s: loader never became ready", name);
      end
   endtask

   task automatic write_word(input string name, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data);
      send_entry(NBF_WR, addr, data);
      wait_ready(name);
   endtask

   task automatic read_word(input string name, input logic [ADDR_W-1:0] addr,
                            output logic [DATA_W-1:0] data);
      int n;
      n = 0;
      send_entry(NBF_RD, addr, '0);
      @(negedge clk);
      while (!rdata_v && n < TIMEOUT)
      begin
         n = n + 1;
         @(negedge clk);
      end
      if (!rdata_v)
      begin
         errors = errors + 1;
         $display("%s: no read data came back for address %h", name, addr);
         data = 'x;
      end
      else
         data = rdata;
   endtask

   task automatic test_reset();
      logic [DATA_W-1:0] got;
      @(negedge clk);
      check_flag("reset freeze", 1'b1, freeze);
      check_flag("reset finish", 1'b0, finish);
      check_flag("reset ready", 1'b0, nbf_ready);
      check_flag("reset loaded", 1'b0, loaded);
      check_flag("reset rdata valid", 1'b0, rdata_v);
      wait_ready("reset");
      read_word("reset", CORE_ID_ADDR, got);
      check_data("reset core id", CFG_CORE_ID, got);
   endtask

   // One word in each block of eight, offsets 4 to 7 stay untouched
   task automatic test_mem_random();
      logic [DATA_W-1:0] got;
      int                idx;
      for (int i = 0; i < 8; i++)
      begin
         idx = i * 8 + int'($urandom % 4);
         wr_addr[i] = 32'h0000_2000 + ADDR_W'(idx * 4);
         wr_data[i] = $urandom;
         write_word("mem random", wr_addr[i], wr_data[i]);
      end
      for (int i = 0; i < 8; i++)
      begin
         read_word("mem random", wr_addr[i], got);
         check_data($sformatf("mem random %0d", i), wr_data[i], got);
      end
   endtask

   task automatic test_mem_overwrite();
      logic [DATA_W-1:0] first;
      logic [DATA_W-1:0] got;
      first = $urandom;
      write_word("mem overwrite", 32'h14, first);
      write_word("mem overwrite", 32'h14, ~first);
      read_word("mem overwrite", 32'h14, got);
      check_data("mem overwrite", ~first, got);
      read_word("mem unwritten", 32'h18, got);
      check_data("mem unwritten", '0, got);
   endtask

   task automatic test_host_regs();
      logic [DATA_W-1:0] got;
      write_word("host freeze", FREEZE_ADDR, '0);
      check_flag("host freeze", 1'b0, freeze);
      check_flag("host finish idle", 1'b0, finish);
      write_word("host finish", FINISH_ADDR, $urandom);
      check_flag("host finish", 1'b1, finish);
      read_word("host freeze read", FREEZE_ADDR, got);
      check_data("host freeze read", '0, got);
   endtask

   task automatic test_done();
      logic seen_ready;
      seen_ready = 1'b0;
      send_entry(NBF_DONE, '0, '0);
      @(negedge clk);
      check_flag("done loaded", 1'b1, loaded);
      // A further entry must stay blocked
      @(posedge clk);
      nbf.op   <= NBF_WR;
      nbf.addr <= 32'h20;
      nbf.data <= $urandom;
      nbf_v    <= 1'b1;
      repeat (20)
      begin
         @(negedge clk);
         seen_ready = seen_ready | nbf_ready;
      end
      check_flag("done ready low", 1'b0, seen_ready);
      check_flag("done loaded held", 1'b1, loaded);
      @(posedge clk);
      nbf_v <= 1'b0;
   endtask

   initial
   begin
      void'($urandom(60));
      clk    = 1'b0;
      arst_n = 1'b0;
      nbf    = '0;
      nbf_v  = 1'b0;
      errors = 0;
      checks = 0;
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;

      test_reset();
      test_mem_random();
      test_mem_overwrite();
      test_host_regs();
      test_done();

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// File: tests/boot_props.sv
// Router protocol properties
`timescale 1ns/1ps

module boot_props
   import boot_pkg::*;
  (input  logic     clk_i
   , input  logic     arst_n_i
   , input  logic     cfg_done_i
   , input  mem_msg_s cfg_cmd_i
   , input  logic     cfg_cmd_v_i
   , input  logic     cfg_cmd_ready_i
   , input  mem_msg_s nbf_cmd_i
   , input  logic     nbf_cmd_v_i
   , input  logic     nbf_cmd_ready_i
   , input  logic     mem_cmd_v_i
   , input  logic     mmio_cmd_v_i
   );

   one_target: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(mem_cmd_v_i && mmio_cmd_v_i))
      else $error("memory and MMIO command valid are high together");

   cfg_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (cfg_cmd_v_i && !cfg_cmd_ready_i) |=> (cfg_cmd_v_i && $stable(cfg_cmd_i)))
      else $error("cfg command dropped or changed before ready");

   nbf_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (nbf_cmd_v_i && !nbf_cmd_ready_i) |=> (nbf_cmd_v_i && $stable(nbf_cmd_i)))
      else $error("nbf command dropped or changed before ready");

   nbf_after_cfg: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !cfg_done_i |-> !nbf_cmd_v_i)
      else $error("nbf command issued before configuration finished");

endmodule

bind cmd_router boot_props boot_props_i
  (.clk_i(clk_i)
   ,.arst_n_i(arst_n_i)
   ,.cfg_done_i(cfg_done_i)
   ,.cfg_cmd_i(cfg_cmd_i)
   ,.cfg_cmd_v_i(cfg_cmd_v_i)
   ,.cfg_cmd_ready_i(cfg_cmd_ready_o)
   ,.nbf_cmd_i(nbf_cmd_i)
   ,.nbf_cmd_v_i(nbf_cmd_v_i)
   ,.nbf_cmd_ready_i(nbf_cmd_ready_o)
   ,.mem_cmd_v_i(mem_cmd_v_o)
   ,.mmio_cmd_v_i(mmio_cmd_v_o)
   );

// File: logic/boot_top.sv
// Boot subsystem top level
`timescale 1ns/1ps

module boot_top
   import boot_pkg::*;
  (input  logic              clk_i
   , input  logic              arst_n_i

   , input  nbf_entry_s        nbf_i
   , input  logic              nbf_v_i
   , output logic              nbf_ready_o
   , output logic [DATA_W-1:0] nbf_rdata_o
   , output logic              nbf_rdata_v_o
   , output logic              loaded_o

   , output logic              freeze_o
   , output logic              program_finish_o
   );

   mem_msg_s cfg_cmd, cfg_resp, nbf_cmd, nbf_resp;
   mem_msg_s mem_cmd, mem_resp, mmio_cmd, mmio_resp;
   logic     cfg_cmd_v, cfg_cmd_ready, cfg_resp_v, cfg_resp_ready;
   logic     nbf_cmd_v, nbf_cmd_ready, nbf_resp_v, nbf_resp_ready;
   logic     mem_cmd_v, mem_cmd_ready, mem_resp_v, mem_resp_ready;
   logic     mmio_cmd_v, mmio_cmd_ready, mmio_resp_v, mmio_resp_ready;
   logic     cfg_done;

   cfg_loader cfg_loader_i
     (.clk_i(clk_i)
      ,.arst_n_i(arst_n_i)
      ,.cmd_o(cfg_cmd)
      ,.cmd_v_o(cfg_cmd_v)
      ,.cmd_ready_i(cfg_cmd_ready)
      ,.resp_i(cfg_resp)
      ,.resp_v_i(cfg_resp_v)
      ,.resp_ready_o(cfg_resp_ready)
      ,.done_o(cfg_done)
      );

   // NBF entries are held off until the configuration is written
   nbf_loader nbf_loader_i
     (.clk_i(clk_i)
      ,.arst_n_i(arst_n_i)
      ,.start_i(cfg_done)
      ,.nbf_i(nbf_i)
      ,.nbf_v_i(nbf_v_i)
      ,.nbf_ready_o(nbf_ready_o)
      ,.cmd_o(nbf_cmd)
      ,.cmd_v_o(nbf_cmd_v)
      ,.cmd_ready_i(nbf_cmd_ready)
      ,.resp_i(nbf_resp)
      ,.resp_v_i(nbf_resp_v)
      ,.resp_ready_o(nbf_resp_ready)
      ,.rdata_o(nbf_rdata_o)
      ,.rdata_v_o(nbf_rdata_v_o)
      ,.done_o(loaded_o)
      );

   cmd_router cmd_router_i
     (.clk_i(clk_i)
      ,.arst_n_i(arst_n_i)
      ,.cfg_done_i(cfg_done)
      ,.cfg_cmd_i(cfg_cmd)
      ,.cfg_cmd_v_i(cfg_cmd_v)
      ,.cfg_cmd_ready_o(cfg_cmd_ready)
      ,.cfg_resp_o(cfg_resp)
      ,.cfg_resp_v_o(cfg_resp_v)
      ,.cfg_resp_ready_i(cfg_resp_ready)
      ,.nbf_cmd_i(nbf_cmd)
      ,.nbf_cmd_v_i(nbf_cmd_v)
      ,.nbf_cmd_ready_o(nbf_cmd_ready)
      ,.nbf_resp_o(nbf_resp)
      ,.nbf_resp_v_o(nbf_resp_v)
      ,.nbf_resp_ready_i(nbf_resp_ready)
      ,.mem_cmd_o(mem_cmd)
      ,.mem_cmd_v_o(mem_cmd_v)
      ,.mem_cmd_ready_i(mem_cmd_ready)
      ,.mem_resp_i(mem_resp)
      ,.mem_resp_v_i(mem_resp_v)
      ,.mem_resp_ready_o(mem_resp_ready)
      ,.mmio_cmd_o(mmio_cmd)
      ,.mmio_cmd_v_o(mmio_cmd_v)
      ,.mmio_cmd_ready_i(mmio_cmd_ready)
      ,.mmio_resp_i(mmio_resp)
      ,.mmio_resp_v_i(mmio_resp_v)
      ,.mmio_resp_ready_o(mmio_resp_ready)
      );

   mem_model mem_model_i
     (.clk_i(clk_i)
      ,.arst_n_i(arst_n_i)
      ,.cmd_i(mem_cmd)
      ,.cmd_v_i(mem_cmd_v)
      ,.cmd_ready_o(mem_cmd_ready)
      ,.resp_o(mem_resp)
      ,.resp_v_o(mem_resp_v)
      ,.resp_ready_i(mem_resp_ready)
      );

   host_mmio host_mmio_i
     (.clk_i(clk_i)
      ,.arst_n_i(arst_n_i)
      ,.cmd_i(mmio_cmd)
      ,.cmd_v_i(mmio_cmd_v)
      ,.cmd_ready_o(mmio_cmd_ready)
      ,.resp_o(mmio_resp)
      ,.resp_v_o(mmio_resp_v)
      ,.resp_ready_i(mmio_resp_ready)
      ,.freeze_o(freeze_o)
      ,.program_finish_o(program_finish_o)
      );

endmodule

// File: logic/host_mmio.sv
// Host control registers
`timescale 1ns/1ps

module host_mmio
   import boot_pkg::*;
  (input  logic     clk_i
   , input  logic     arst_n_i

   , input  mem_msg_s cmd_i
   , input  logic     cmd_v_i
   , output logic     cmd_ready_o

   , output mem_msg_s resp_o
   , output logic     resp_v_o
   , input  logic     resp_ready_i

   , output logic     freeze_o
   , output logic     program_finish_o
   );

   logic [DATA_W-1:0] core_id_q;
   logic              freeze_q;
   logic              finish_q;
   logic              resp_v_q;
   logic              cmd_accept;
   logic [DATA_W-1:0] rd_data;
   mem_msg_s          resp_q;

   assign cmd_ready_o      = ~resp_v_q;
   assign cmd_accept       = cmd_v_i & cmd_ready_o;
   assign resp_o           = resp_q;
   assign resp_v_o         = resp_v_q;
   assign freeze_o         = freeze_q;
   assign program_finish_o = finish_q;

   always_comb
   begin
      case (cmd_i.addr)
         CORE_ID_ADDR: rd_data = core_id_q;
         FREEZE_ADDR:  rd_data = {{(DATA_W-1){1'b0}}, freeze_q};
         FINISH_ADDR:  rd_data = {{(DATA_W-1){1'b0}}, finish_q};
         default:      rd_data = '0;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         core_id_q <= '0;
         freeze_q  <= 1'b1;
         finish_q  <= 1'b0;
         resp_v_q  <= 1'b0;
      end
      else
      begin
         if (cmd_accept)
         begin
            resp_v_q <= 1'b1;
            if (cmd_i.op == MEM_WR)
            begin
               case (cmd_i.addr)
                  CORE_ID_ADDR: core_id_q <= cmd_i.data;
                  FREEZE_ADDR:  freeze_q  <= cmd_i.data[0];
                  // Any value marks the program finished
                  FINISH_ADDR:  finish_q  <= 1'b1;
                  default:      ;
               endcase
            end
         end
         else if (resp_v_q && resp_ready_i)
            resp_v_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (cmd_accept)
      begin
         resp_q.op   <= cmd_i.op;
         resp_q.addr <= cmd_i.addr;
         resp_q.data <= (cmd_i.op == MEM_WR) ? '0 : rd_data;
      end
   end

endmodule

// File: logic/mem_model.sv
// Fixed latency word memory
`timescale 1ns/1ps

module mem_model
   import boot_pkg::*;
  (input  logic     clk_i
   , input  logic     arst_n_i

   , input  mem_msg_s cmd_i
   , input  logic     cmd_v_i
   , output logic     cmd_ready_o

   , output mem_msg_s resp_o
   , output logic     resp_v_o
   , input  logic     resp_ready_i
   );

   logic [DATA_W-1:0]    mem_q [MEM_WORDS];
   logic [MEM_IDX_W-1:0] cmd_idx;
   logic [MEM_LAT_W-1:0] cnt_q;
   logic                 busy_q;
   logic                 cmd_accept;
   mem_msg_s             resp_q;

   // Word index, higher address bits alias
   assign cmd_idx     = cmd_i.addr[MEM_IDX_W+1:2];
   assign cmd_ready_o = ~busy_q;
   assign cmd_accept  = cmd_v_i & cmd_ready_o;
   assign resp_v_o    = busy_q & (cnt_q == '0);
   assign resp_o      = resp_q;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
         for (int i = 0; i < MEM_WORDS; i++)
            mem_q[i] <= '0;
      end
      else
      begin
         if (cmd_accept)
         begin
            busy_q <= 1'b1;
            cnt_q  <= MEM_LAT_W'(MEM_LATENCY - 1);
            if (cmd_i.op == MEM_WR)
               mem_q[cmd_idx] <= cmd_i.data;
         end
         else if (busy_q && cnt_q != '0)
            cnt_q <= cnt_q - 1'b1;
         else if (resp_v_o && resp_ready_i)
            busy_q <= 1'b0;
      end
   end

   // Read data is sampled on accept and held until the response leaves
   always_ff @(posedge clk_i)
   begin
      if (cmd_accept)
      begin
         resp_q.op   <= cmd_i.op;
         resp_q.addr <= cmd_i.addr;
         resp_q.data <= (cmd_i.op == MEM_WR) ? '0 : mem_q[cmd_idx];
      end
   end

endmodule

// File: logic/cmd_router.sv
// Load path arbiter and address router
`timescale 1ns/1ps

module cmd_router
   import boot_pkg::*;
  (input  logic     clk_i
   , input  logic     arst_n_i
   , input  logic     cfg_done_i

   , input  mem_msg_s cfg_cmd_i
   , input  logic     cfg_cmd_v_i
   , output logic     cfg_cmd_ready_o
   , output mem_msg_s cfg_resp_o
   , output logic     cfg_resp_v_o
   , input  logic     cfg_resp_ready_i

   , input  mem_msg_s nbf_cmd_i
   , input  logic     nbf_cmd_v_i
   , output logic     nbf_cmd_ready_o
   , output mem_msg_s nbf_resp_o
   , output logic     nbf_resp_v_o
   , input  logic     nbf_resp_ready_i

   , output mem_msg_s mem_cmd_o
   , output logic     mem_cmd_v_o
   , input  logic     mem_cmd_ready_i
   , input  mem_msg_s mem_resp_i
   , input  logic     mem_resp_v_i
   , output logic     mem_resp_ready_o

   , output mem_msg_s mmio_cmd_o
   , output logic     mmio_cmd_v_o
   , input  logic     mmio_cmd_ready_i
   , input  mem_msg_s mmio_resp_i
   , input  logic     mmio_resp_v_i
   , output logic     mmio_resp_ready_o
   );

   mem_msg_s load_cmd;
   mem_msg_s load_resp;
   logic     load_cmd_v;
   logic     load_cmd_ready;
   logic     load_resp_v;
   logic     load_resp_ready;
   logic     cmd_is_mmio;
   logic     owner_mmio_q;

   // Loaders never overlap, so a fixed select on cfg_done is enough
   assign load_cmd        = cfg_done_i ? nbf_cmd_i : cfg_cmd_i;
   assign load_cmd_v      = cfg_done_i ? nbf_cmd_v_i : cfg_cmd_v_i;
   assign load_resp_ready = cfg_done_i ? nbf_resp_ready_i : cfg_resp_ready_i;

   assign cmd_is_mmio =
      (load_cmd.addr[ADDR_W-1:MMIO_SPAN_W] == MMIO_BASE[ADDR_W-1:MMIO_SPAN_W]);

   assign mem_cmd_o      = load_cmd;
   assign mmio_cmd_o     = load_cmd;
   assign mem_cmd_v_o    = load_cmd_v & ~cmd_is_mmio;
   assign mmio_cmd_v_o   = load_cmd_v & cmd_is_mmio;
   assign load_cmd_ready = cmd_is_mmio ? mmio_cmd_ready_i : mem_cmd_ready_i;

   assign cfg_cmd_ready_o = ~cfg_done_i & load_cmd_ready;
   assign nbf_cmd_ready_o = cfg_done_i & load_cmd_ready;

   // Only the target that took the pending command may answer
   assign load_resp         = owner_mmio_q ? mmio_resp_i : mem_resp_i;
   assign load_resp_v       = owner_mmio_q ? mmio_resp_v_i : mem_resp_v_i;
   assign mem_resp_ready_o  = ~owner_mmio_q & load_resp_ready;
   assign mmio_resp_ready_o = owner_mmio_q & load_resp_ready;

   assign cfg_resp_o   = cfg_done_i ? '0 : load_resp;
   assign cfg_resp_v_o = ~cfg_done_i & load_resp_v;
   assign nbf_resp_o   = cfg_done_i ? load_resp : '0;
   assign nbf_resp_v_o = cfg_done_i & load_resp_v;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         owner_mmio_q <= 1'b0;
      else if (load_cmd_v && load_cmd_ready)
         owner_mmio_q <= cmd_is_mmio;
   end

endmodule

// File: logic/nbf_loader.sv
// NBF entry loader
`timescale 1ns/1ps

module nbf_loader
   import boot_pkg::*;
  (input  logic              clk_i
   , input  logic              arst_n_i
   , input  logic              start_i

   , input  nbf_entry_s        nbf_i
   , input  logic              nbf_v_i
   , output logic              nbf_ready_o

   , output mem_msg_s          cmd_o
   , output logic              cmd_v_o
   , input  logic              cmd_ready_i

   , input  mem_msg_s          resp_i
   , input  logic              resp_v_i
   , output logic              resp_ready_o

   , output logic [DATA_W-1:0] rdata_o
   , output logic              rdata_v_o
   , output logic              done_o
   );

   mem_msg_s          entry_q;
   logic [DATA_W-1:0] rdata_q;
   logic              cmd_v_q;
   logic              wait_q;
   logic              done_q;
   logic              rdata_v_q;
   logic              nbf_accept;

   // One entry in flight, from accept until its response returns
   assign nbf_ready_o  = start_i & ~cmd_v_q & ~wait_q & ~done_q;
   assign nbf_accept   = nbf_v_i & nbf_ready_o;

   assign cmd_o        = entry_q;
   assign cmd_v_o      = cmd_v_q;
   assign resp_ready_o = wait_q;
   assign rdata_o      = rdata_q;
   assign rdata_v_o    = rdata_v_q;
   assign done_o       = done_q;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         cmd_v_q   <= 1'b0;
         wait_q    <= 1'b0;
         done_q    <= 1'b0;
         rdata_v_q <= 1'b0;
      end
      else
      begin
         rdata_v_q <= 1'b0;
         if (nbf_accept)
         begin
            if (nbf_i.op == NBF_DONE)
               done_q <= 1'b1;
            else
               cmd_v_q <= 1'b1;
         end
         if (cmd_v_q && cmd_ready_i)
         begin
            cmd_v_q <= 1'b0;
            wait_q  <= 1'b1;
         end
         if (wait_q && resp_v_i)
         begin
            wait_q    <= 1'b0;
            rdata_v_q <= (entry_q.op == MEM_RD);
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (nbf_accept)
      begin
         entry_q.op   <= (nbf_i.op == NBF_RD) ? MEM_RD : MEM_WR;
         entry_q.addr <= nbf_i.addr;
         entry_q.data <= (nbf_i.op == NBF_RD) ? '0 : nbf_i.data;
      end
      if (wait_q && resp_v_i)
         rdata_q <= resp_i.data;
   end

endmodule

// File: logic/cfg_loader.sv
// Configuration loader
`timescale 1ns/1ps

module cfg_loader
   import boot_pkg::*;
  (input  logic     clk_i
   , input  logic     arst_n_i

   , output mem_msg_s cmd_o
   , output logic     cmd_v_o
   , input  logic     cmd_ready_i

   , input  mem_msg_s resp_i
   , input  logic     resp_v_i
   , output logic     resp_ready_o

   , output logic     done_o
   );

   cfg_state_e           state_q;
   logic [CFG_IDX_W-1:0] idx_q;
   logic                 last_entry;

   assign last_entry = (idx_q == CFG_IDX_W'(CFG_LEN - 1));

   assign cmd_o        = CFG_TABLE[idx_q];
   assign cmd_v_o      = (state_q == CFG_SEND);
   assign resp_ready_o = (state_q == CFG_WAIT);
   assign done_o       = (state_q == CFG_DONE);

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q <= CFG_SEND;
         idx_q   <= '0;
      end
      else
      begin
         case (state_q)
            CFG_SEND:
               if (cmd_ready_i)
                  state_q <= CFG_WAIT;
            CFG_WAIT:
               if (resp_v_i)
               begin
                  if (last_entry)
                     state_q <= CFG_DONE;
                  else
                  begin
                     idx_q   <= idx_q + 1'b1;
                     state_q <= CFG_SEND;
                  end
               end
            default:
               state_q <= CFG_DONE;
         endcase
      end
   end

endmodule

// File: logic/boot_pkg.sv
// Boot subsystem definitions
package boot_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   typedef enum logic
   {
      MEM_RD = 1'b0,
      MEM_WR = 1'b1
   } mem_op_e;

   typedef enum logic [1:0]
   {
      NBF_WR   = 2'd0,
      NBF_RD   = 2'd1,
      NBF_DONE = 2'd2
   } nbf_op_e;

   // Shared by commands and responses
   typedef struct packed
   {
      mem_op_e           op;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } mem_msg_s;

   typedef struct packed
   {
      nbf_op_e           op;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } nbf_entry_s;

   // MMIO region is MMIO_BASE up to MMIO_BASE + 4 KiB
   localparam logic [ADDR_W-1:0] MMIO_BASE    = 32'h0010_0000;
   localparam int                MMIO_SPAN_W  = 12;
   localparam logic [ADDR_W-1:0] CORE_ID_ADDR = MMIO_BASE + 32'h0;
   localparam logic [ADDR_W-1:0] FREEZE_ADDR  = MMIO_BASE + 32'h4;
   localparam logic [ADDR_W-1:0] FINISH_ADDR  = MMIO_BASE + 32'h8;

   localparam logic [DATA_W-1:0] CFG_CORE_ID = 32'd3;
   localparam int                CFG_LEN     = 1;
   localparam int                CFG_IDX_W   = (CFG_LEN > 1) ? $clog2(CFG_LEN) : 1;
   localparam mem_msg_s [CFG_LEN-1:0] CFG_TABLE =
      {mem_msg_s'{op: MEM_WR, addr: CORE_ID_ADDR, data: CFG_CORE_ID}};

   localparam int MEM_WORDS   = 64;
   localparam int MEM_IDX_W   = $clog2(MEM_WORDS);
   localparam int MEM_LATENCY = 4;
   localparam int MEM_LAT_W   = $clog2(MEM_LATENCY + 1);

   typedef enum logic [1:0]
   {
      CFG_SEND = 2'd0,
      CFG_WAIT = 2'd1,
      CFG_DONE = 2'd2
   } cfg_state_e;

endpackage
